// ==== soc_bus_pkg.sv ====
// Shared bus types and address map
`default_nettype none

package soc_bus_pkg;

  // Bus vectors
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Main memory size
  localparam int MEM_WORDS = 1024;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  //////////////////////////////
  // Region codes on addr[31:28]
  //////////////////////////////
  localparam logic [3:0] SEL_MEM = 4'h0;
  localparam logic [3:0] SEL_KEY = 4'h1;
  localparam logic [3:0] SEL_DMA = 4'h2;

  // Returned for reads that hit no slave
  localparam data_t UNMAPPED_DATA = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== soc_dev_pkg.sv ====
// Device register map and types
`default_nettype none

package soc_dev_pkg;

  // Keyboard
  typedef logic [7:0] key_code_t;
  localparam int KEY_DEPTH = 4;
  localparam int KEY_PTR_W = $clog2(KEY_DEPTH);

  localparam logic [3:0] KEY_DATA_OFS = 4'h0;
  localparam logic [3:0] KEY_STAT_OFS = 4'h4;

  // DMA register offsets
  localparam logic [3:0] DMA_SRC_OFS  = 4'h0;
  localparam logic [3:0] DMA_DST_OFS  = 4'h4;
  localparam logic [3:0] DMA_LEN_OFS  = 4'h8;
  localparam logic [3:0] DMA_CTRL_OFS = 4'hC;

  // Copy engine states
  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE,
    DONE
  } dma_state_t;

endpackage

`default_nettype wire

// ==== wb_if.sv ====
// Shared bus interface
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

  // Request, held by the master until ack
  logic                cyc;
  logic                we;
  soc_bus_pkg::strb_t  strb;
  soc_bus_pkg::addr_t  addr;
  soc_bus_pkg::data_t  wdata;

  // Response, one cycle pulse
  logic                ack;
  soc_bus_pkg::data_t  rdata;

  modport master (
    output cyc, we, strb, addr, wdata,
    input  ack, rdata
  );

  modport slave (
    input  cyc, we, strb, addr, wdata,
    output ack, rdata
  );

endinterface

`default_nettype wire

// ==== wish_bus.sv ====
// Bus arbiter and address decoder
`timescale 1ns/1ps
`default_nettype none

module wish_bus (
  input logic clk,
  input logic arst_n_i,
  wb_if.slave  host_s,
  wb_if.slave  dma_s,
  wb_if.master mem_m,
  wb_if.master key_m,
  wb_if.master dma_reg_m
);

  logic               gnt_host_q;
  logic               gnt_dma_q;
  logic               unmap_ack_q;
  logic               req_cyc;
  logic               req_we;
  soc_bus_pkg::strb_t req_strb;
  soc_bus_pkg::addr_t req_addr;
  soc_bus_pkg::data_t req_wdata;
  logic [3:0]         sel;
  logic               unmapped;
  logic               rsp_ack;
  soc_bus_pkg::data_t rsp_data;

  //////////////////////////////
  // Grant
  //////////////////////////////

  // Host wins when both ask on a free bus
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_host_q <= 1'b0;
      gnt_dma_q  <= 1'b0;
    end else if (gnt_host_q || gnt_dma_q) begin
      if (rsp_ack) begin
        gnt_host_q <= 1'b0;
        gnt_dma_q  <= 1'b0;
      end
    end else begin
      gnt_host_q <= host_s.cyc;
      gnt_dma_q  <= dma_s.cyc & ~host_s.cyc;
    end
  end

  //////////////////////////////
  // Request path
  //////////////////////////////

  assign req_cyc   = (gnt_host_q & host_s.cyc) | (gnt_dma_q & dma_s.cyc);
  assign req_we    = gnt_dma_q ? dma_s.we    : host_s.we;
  assign req_strb  = gnt_dma_q ? dma_s.strb  : host_s.strb;
  assign req_addr  = gnt_dma_q ? dma_s.addr  : host_s.addr;
  assign req_wdata = gnt_dma_q ? dma_s.wdata : host_s.wdata;

  assign sel      = req_addr[31:28];
  assign unmapped = (sel != soc_bus_pkg::SEL_MEM) && (sel != soc_bus_pkg::SEL_KEY) &&
                    (sel != soc_bus_pkg::SEL_DMA);

  assign mem_m.cyc   = req_cyc & (sel == soc_bus_pkg::SEL_MEM);
  assign mem_m.we    = req_we;
  assign mem_m.strb  = req_strb;
  assign mem_m.addr  = req_addr;
  assign mem_m.wdata = req_wdata;

  assign key_m.cyc   = req_cyc & (sel == soc_bus_pkg::SEL_KEY);
  assign key_m.we    = req_we;
  assign key_m.strb  = req_strb;
  assign key_m.addr  = req_addr;
  assign key_m.wdata = req_wdata;

  assign dma_reg_m.cyc   = req_cyc & (sel == soc_bus_pkg::SEL_DMA);
  assign dma_reg_m.we    = req_we;
  assign dma_reg_m.strb  = req_strb;
  assign dma_reg_m.addr  = req_addr;
  assign dma_reg_m.wdata = req_wdata;

  // Local answer for holes in the map, one pulse per cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unmap_ack_q <= 1'b0;
    end else begin
      unmap_ack_q <= req_cyc & unmapped & ~unmap_ack_q;
    end
  end

  //////////////////////////////
  // Response path
  //////////////////////////////

  always_comb begin
    rsp_ack  = unmap_ack_q;
    rsp_data = soc_bus_pkg::UNMAPPED_DATA;
    case (sel)
      soc_bus_pkg::SEL_MEM: begin
        rsp_ack  = mem_m.ack;
        rsp_data = mem_m.rdata;
      end
      soc_bus_pkg::SEL_KEY: begin
        rsp_ack  = key_m.ack;
        rsp_data = key_m.rdata;
      end
      soc_bus_pkg::SEL_DMA: begin
        rsp_ack  = dma_reg_m.ack;
        rsp_data = dma_reg_m.rdata;
      end
      default: ;
    endcase
  end

  assign host_s.ack   = gnt_host_q & rsp_ack;
  assign host_s.rdata = rsp_data;
  assign dma_s.ack    = gnt_dma_q & rsp_ack;
  assign dma_s.rdata  = rsp_data;

endmodule

`default_nettype wire

// ==== main_mem.sv ====
// Main memory with byte enables
`timescale 1ns/1ps
`default_nettype none

module main_mem (
  input logic clk,
  input logic arst_n_i,
  wb_if.slave bus
);

  soc_bus_pkg::data_t             mem_q [soc_bus_pkg::MEM_WORDS];
  soc_bus_pkg::data_t             rdata_q;
  logic [soc_bus_pkg::MEM_AW-1:0] idx;
  logic                           accept;
  logic                           ack_q;

  // Word index, byte offset dropped
  assign idx    = bus.addr[soc_bus_pkg::MEM_AW+1:2];
  assign accept = bus.cyc & ~ack_q;

  // Array access
  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= mem_q[idx];
      if (bus.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.strb[b]) mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // No second ack while cyc is still held
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== keyboard.sv ====
// Keyboard scan code queue
`timescale 1ns/1ps
`default_nettype none

module keyboard (
  input logic                  clk,
  input logic                  arst_n_i,
  wb_if.slave                  bus,
  input logic                  key_strobe_i,
  input soc_dev_pkg::key_code_t key_code_i
);

  soc_dev_pkg::key_code_t          fifo_q [soc_dev_pkg::KEY_DEPTH];
  logic [soc_dev_pkg::KEY_PTR_W-1:0] wr_ptr_q;
  logic [soc_dev_pkg::KEY_PTR_W-1:0] rd_ptr_q;
  logic [soc_dev_pkg::KEY_PTR_W:0]   count_q;
  soc_bus_pkg::data_t              rd_word;
  soc_bus_pkg::data_t              rdata_q;
  logic                            accept;
  logic                            ack_q;
  logic                            empty;
  logic                            full;
  logic                            push;
  logic                            pop;

  assign accept = bus.cyc & ~ack_q;
  assign empty  = (count_q == '0);
  assign full   = (count_q == soc_dev_pkg::KEY_DEPTH);
  // Codes arriving on a full queue are lost
  assign push   = key_strobe_i & ~full;
  assign pop    = accept & ~bus.we & (bus.addr[3:0] == soc_dev_pkg::KEY_DATA_OFS) & ~empty;

  always_ff @(posedge clk) begin
    if (push) fifo_q[wr_ptr_q] <= key_code_i;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= accept;
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Data reads carry valid in bit 8
  always_comb begin
    rd_word = '0;
    case (bus.addr[3:0])
      soc_dev_pkg::KEY_DATA_OFS: if (!empty) rd_word = {23'd0, 1'b1, fifo_q[rd_ptr_q]};
      soc_dev_pkg::KEY_STAT_OFS: rd_word = soc_bus_pkg::data_t'(count_q);
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) rdata_q <= rd_word;
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== disk_dma.sv ====
// Disk DMA copy engine
`timescale 1ns/1ps
`default_nettype none

module disk_dma (
  input  logic clk,
  input  logic arst_n_i,
  wb_if.slave  regs,
  wb_if.master mem,
  output logic irq_o,
  input  logic irq_clear_i
);

  soc_dev_pkg::dma_state_t state_q;
  soc_dev_pkg::dma_state_t state_d;
  soc_bus_pkg::addr_t      src_q;
  soc_bus_pkg::addr_t      dst_q;
  soc_bus_pkg::addr_t      cur_src_q;
  soc_bus_pkg::addr_t      cur_dst_q;
  soc_bus_pkg::data_t      len_q;
  soc_bus_pkg::data_t      rem_q;
  soc_bus_pkg::data_t      buf_q;
  soc_bus_pkg::data_t      reg_word;
  soc_bus_pkg::data_t      reg_rdata_q;
  logic [3:0]              ofs;
  logic                    reg_accept;
  logic                    reg_ack_q;
  logic                    busy;
  logic                    start;
  logic                    done_q;

  //////////////////////////////
  // Register port
  //////////////////////////////

  assign ofs        = regs.addr[3:0];
  assign reg_accept = regs.cyc & ~reg_ack_q;
  assign busy       = (state_q != soc_dev_pkg::IDLE);
  // Start requests during a copy are dropped
  assign start      = reg_accept & regs.we & (ofs == soc_dev_pkg::DMA_CTRL_OFS) &
                      regs.wdata[0] & ~busy;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
      reg_ack_q <= 1'b0;
    end else begin
      reg_ack_q <= reg_accept;
      if (reg_accept && regs.we) begin
        case (ofs)
          soc_dev_pkg::DMA_SRC_OFS: src_q <= regs.wdata;
          soc_dev_pkg::DMA_DST_OFS: dst_q <= regs.wdata;
          soc_dev_pkg::DMA_LEN_OFS: len_q <= regs.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (ofs)
      soc_dev_pkg::DMA_SRC_OFS:  reg_word = src_q;
      soc_dev_pkg::DMA_DST_OFS:  reg_word = dst_q;
      soc_dev_pkg::DMA_LEN_OFS:  reg_word = len_q;
      soc_dev_pkg::DMA_CTRL_OFS: reg_word = {30'd0, done_q, busy};
      default:                   reg_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_accept) reg_rdata_q <= reg_word;
  end

  assign regs.ack   = reg_ack_q;
  assign regs.rdata = reg_rdata_q;

  //////////////////////////////
  // Copy engine
  //////////////////////////////

  // One read then one write per word
  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_dev_pkg::IDLE: begin
        if (start && len_q == '0) state_d = soc_dev_pkg::DONE;
        else if (start) state_d = soc_dev_pkg::READ;
      end
      soc_dev_pkg::READ: if (mem.ack) state_d = soc_dev_pkg::WRITE;
      soc_dev_pkg::WRITE: begin
        if (mem.ack && rem_q == 32'd1) state_d = soc_dev_pkg::DONE;
        else if (mem.ack) state_d = soc_dev_pkg::READ;
      end
      default: state_d = soc_dev_pkg::IDLE;
    endcase
  end

  // done doubles as the level interrupt, setting wins over clear
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= soc_dev_pkg::IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == soc_dev_pkg::DONE) done_q <= 1'b1;
      else if (irq_clear_i) done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      cur_src_q <= src_q;
      cur_dst_q <= dst_q;
      rem_q     <= len_q;
    end
    if (state_q == soc_dev_pkg::READ && mem.ack) begin
      buf_q     <= mem.rdata;
      cur_src_q <= cur_src_q + 32'd4;
    end
    if (state_q == soc_dev_pkg::WRITE && mem.ack) begin
      cur_dst_q <= cur_dst_q + 32'd4;
      rem_q     <= rem_q - 32'd1;
    end
  end

  assign mem.cyc   = (state_q == soc_dev_pkg::READ) || (state_q == soc_dev_pkg::WRITE);
  assign mem.we    = (state_q == soc_dev_pkg::WRITE);
  assign mem.strb  = 4'hF;
  assign mem.addr  = (state_q == soc_dev_pkg::WRITE) ? cur_dst_q : cur_src_q;
  assign mem.wdata = buf_q;

  assign irq_o = done_q;

endmodule

`default_nettype wire

// ==== system.sv ====
// SoC top level
`timescale 1ns/1ps
`default_nettype none

module system (
  input  logic                   clk,
  input  logic                   arst_n_i,
  // Host master port
  input  logic                   host_cyc_i,
  input  logic                   host_we_i,
  input  soc_bus_pkg::strb_t     host_strb_i,
  input  soc_bus_pkg::addr_t     host_addr_i,
  input  soc_bus_pkg::data_t     host_data_i,
  output logic                   host_ack_o,
  output soc_bus_pkg::data_t     host_data_o,
  // Keyboard input
  input  logic                   key_strobe_i,
  input  soc_dev_pkg::key_code_t key_code_i,
  // DMA interrupt
  output logic                   irq_o,
  input  logic                   irq_clear_i
);

  wb_if host_bus ();
  wb_if dma_m_bus ();
  wb_if mem_bus ();
  wb_if key_bus ();
  wb_if dma_s_bus ();

  // Host pins onto the bus
  assign host_bus.cyc   = host_cyc_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.strb  = host_strb_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_data_i;
  assign host_ack_o     = host_bus.ack;
  assign host_data_o    = host_bus.rdata;

  //////////////////////////////
  // Bus and devices
  //////////////////////////////

  wish_bus u_wish_bus (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .host_s    (host_bus.slave),
    .dma_s     (dma_m_bus.slave),
    .mem_m     (mem_bus.master),
    .key_m     (key_bus.master),
    .dma_reg_m (dma_s_bus.master)
  );

  main_mem u_main_mem (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .bus      (mem_bus.slave)
  );

  keyboard u_keyboard (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .bus          (key_bus.slave),
    .key_strobe_i (key_strobe_i),
    .key_code_i   (key_code_i)
  );

  disk_dma u_disk_dma (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .regs        (dma_s_bus.slave),
    .mem         (dma_m_bus.master),
    .irq_o       (irq_o),
    .irq_clear_i (irq_clear_i)
  );

endmodule

`default_nettype wire

// ==== system_checker.sv ====
// Bus protocol and interrupt assertions
`timescale 1ns/1ps
`default_nettype none

module system_checker (
  input logic                    clk,
  input logic                    arst_n_i,
  input logic                    host_cyc_i,
  input logic                    host_ack_o,
  input logic                    irq_o,
  input logic                    irq_clear_i,
  input soc_dev_pkg::dma_state_t dma_state_i
);

  // Ack is a one cycle pulse
  ack_single: assert property (@(posedge clk) disable iff (!arst_n_i)
    host_ack_o |=> !host_ack_o)
    else $error("host_ack_o high for two cycles in a row");

  // Ack only while the host request is up
  ack_with_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
    host_ack_o |-> host_cyc_i)
    else $error("host_ack_o without host_cyc_i");

  // A copy finishing in the clear cycle sets the interrupt again
  irq_cleared: assert property (@(posedge clk) disable iff (!arst_n_i)
    (irq_clear_i && dma_state_i != soc_dev_pkg::DONE) |=> !irq_o)
    else $error("irq_o still high after irq_clear_i");

endmodule

bind system system_checker u_system_checker (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .host_cyc_i  (host_cyc_i),
  .host_ack_o  (host_ack_o),
  .irq_o       (irq_o),
  .irq_clear_i (irq_clear_i),
  .dma_state_i (u_disk_dma.state_q)
);

`default_nettype wire

// ==== tb_system.sv ====
// SoC directed testbench
`timescale 1ns/1ps
`default_nettype none

module tb_system;

  localparam int ACK_TIMEOUT = 200;
  localparam int IRQ_TIMEOUT = 2000;

  logic                   clk;
  logic                   arst_n_i;
  logic                   host_cyc_i;
  logic                   host_we_i;
  soc_bus_pkg::strb_t     host_strb_i;
  soc_bus_pkg::addr_t     host_addr_i;
  soc_bus_pkg::data_t     host_data_i;
  logic                   host_ack_o;
  soc_bus_pkg::data_t     host_data_o;
  logic                   key_strobe_i;
  soc_dev_pkg::key_code_t key_code_i;
  logic                   irq_o;
  logic                   irq_clear_i;

  // Expected memory contents, keyed by byte address
  soc_bus_pkg::data_t mem_model [soc_bus_pkg::addr_t];
  int                 tests;
  int                 checks;
  int                 errors;
  int                 test_start_errors;

  system DUT (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .host_cyc_i   (host_cyc_i),
    .host_we_i    (host_we_i),
    .host_strb_i  (host_strb_i),
    .host_addr_i  (host_addr_i),
    .host_data_i  (host_data_i),
    .host_ack_o   (host_ack_o),
    .host_data_o  (host_data_o),
    .key_strobe_i (key_strobe_i),
    .key_code_i   (key_code_i),
    .irq_o        (irq_o),
    .irq_clear_i  (irq_clear_i)
  );

  always #20 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("Error: %s", why);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic check_data(input string name, input soc_bus_pkg::data_t got,
                            input soc_bus_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Requests are raised on a falling edge, ack is sampled there too
  task automatic wait_host_ack(output soc_bus_pkg::data_t rdata);
    int cycles;
    cycles = 0;
    rdata  = '0;
    @(negedge clk);
    while (!host_ack_o && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!host_ack_o) begin
      abort_run("the bus gave no ack to the host within the timeout");
    end else begin
      rdata = host_data_o;
      // Request stays up until the ack cycle has ended
      @(negedge clk);
      host_cyc_i = 1'b0;
      host_we_i  = 1'b0;
    end
  endtask

  task automatic bus_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t data,
                           input soc_bus_pkg::strb_t strb);
    soc_bus_pkg::data_t unused;
    host_cyc_i  = 1'b1;
    host_we_i   = 1'b1;
    host_strb_i = strb;
    host_addr_i = addr;
    host_data_i = data;
    wait_host_ack(unused);
  endtask

  task automatic bus_read(input soc_bus_pkg::addr_t addr, output soc_bus_pkg::data_t data);
    host_cyc_i  = 1'b1;
    host_we_i   = 1'b0;
    host_strb_i = 4'hF;
    host_addr_i = addr;
    wait_host_ack(data);
  endtask

  function automatic soc_bus_pkg::data_t merge_bytes(input soc_bus_pkg::data_t old_w,
                                                     input soc_bus_pkg::data_t new_w,
                                                     input soc_bus_pkg::strb_t strb);
    soc_bus_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // Full word write that also updates the model
  task automatic mem_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t data);
    mem_model[addr] = data;
    bus_write(addr, data, 4'hF);
  endtask

  task automatic mem_read_check(input soc_bus_pkg::addr_t addr);
    soc_bus_pkg::data_t got;
    bus_read(addr, got);
    check_data($sformatf("host_data_o @0x%08h", addr), got, mem_model[addr]);
  endtask

  function automatic soc_bus_pkg::addr_t dma_reg(input logic [3:0] ofs);
    return {soc_bus_pkg::SEL_DMA, 24'd0, ofs};
  endfunction

  function automatic soc_bus_pkg::addr_t key_reg(input logic [3:0] ofs);
    return {soc_bus_pkg::SEL_KEY, 24'd0, ofs};
  endfunction

  task automatic key_push(input soc_dev_pkg::key_code_t code);
    key_code_i   = code;
    key_strobe_i = 1'b1;
    @(negedge clk);
    key_strobe_i = 1'b0;
  endtask

  task automatic start_copy(input soc_bus_pkg::addr_t src, input soc_bus_pkg::addr_t dst,
                            input int words);
    bus_write(dma_reg(soc_dev_pkg::DMA_SRC_OFS), src, 4'hF);
    bus_write(dma_reg(soc_dev_pkg::DMA_DST_OFS), dst, 4'hF);
    bus_write(dma_reg(soc_dev_pkg::DMA_LEN_OFS), 32'(words), 4'hF);
    bus_write(dma_reg(soc_dev_pkg::DMA_CTRL_OFS), 32'h1, 4'hF);
  endtask

  task automatic wait_irq();
    int cycles;
    cycles = 0;
    while (!irq_o && cycles < IRQ_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!irq_o) abort_run("the DMA interrupt did not rise within the timeout");
  endtask

  // Reads back the copy and clears the interrupt
  task automatic finish_copy(input soc_bus_pkg::addr_t src, input soc_bus_pkg::addr_t dst,
                             input int words);
    soc_bus_pkg::data_t ctrl;
    wait_irq();
    for (int i = 0; i < words; i++) begin
      mem_model[dst + 32'(4 * i)] = mem_model[src + 32'(4 * i)];
      mem_read_check(dst + 32'(4 * i));
    end
    bus_read(dma_reg(soc_dev_pkg::DMA_CTRL_OFS), ctrl);
    // done set, busy clear
    check_data("host_data_o dma ctrl", ctrl, 32'h2);
    irq_clear_i = 1'b1;
    @(negedge clk);
    irq_clear_i = 1'b0;
    check_bit("irq_o", irq_o, 1'b0);
  endtask

  task automatic start_test();
    tests++;
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_start_errors) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - test_start_errors);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_mem_rw();
    start_test();
    for (int i = 0; i < 8; i++) mem_write(32'(i * 32'h84), $urandom);
    for (int i = 0; i < 8; i++) mem_read_check(32'(i * 32'h84));
    end_test("memory read and write");
  endtask

  task automatic test_byte_strobes();
    soc_bus_pkg::addr_t addr;
    soc_bus_pkg::data_t part;
    start_test();
    addr = 32'h0000_0FF0;
    mem_write(addr, $urandom);
    part = $urandom;
    mem_model[addr] = merge_bytes(mem_model[addr], part, 4'b1010);
    bus_write(addr, part, 4'b1010);
    mem_read_check(addr);
    part = $urandom;
    mem_model[addr] = merge_bytes(mem_model[addr], part, 4'b0001);
    bus_write(addr, part, 4'b0001);
    mem_read_check(addr);
    end_test("byte strobes");
  endtask

  task automatic test_keyboard();
    soc_dev_pkg::key_code_t codes [5];
    soc_bus_pkg::data_t     got;
    start_test();
    codes = '{8'h1C, 8'h32, 8'h21, 8'h5A, 8'h76};
    for (int i = 0; i < 3; i++) key_push(codes[i]);
    bus_read(key_reg(soc_dev_pkg::KEY_STAT_OFS), got);
    check_data("host_data_o key status", got, 32'd3);
    for (int i = 0; i < 3; i++) begin
      bus_read(key_reg(soc_dev_pkg::KEY_DATA_OFS), got);
      check_data("host_data_o key data", got, {23'd0, 1'b1, codes[i]});
    end
    bus_read(key_reg(soc_dev_pkg::KEY_DATA_OFS), got);
    check_bit("host_data_o[8] key valid on empty queue", got[8], 1'b0);
    // Burst of five into a queue of four
    for (int i = 0; i < 5; i++) key_push(codes[i]);
    bus_read(key_reg(soc_dev_pkg::KEY_STAT_OFS), got);
    check_data("host_data_o key status", got, 32'd4);
    for (int i = 0; i < 4; i++) begin
      bus_read(key_reg(soc_dev_pkg::KEY_DATA_OFS), got);
      check_data("host_data_o key data", got, {23'd0, 1'b1, codes[i]});
    end
    bus_read(key_reg(soc_dev_pkg::KEY_DATA_OFS), got);
    check_bit("host_data_o[8] key valid after dropped code", got[8], 1'b0);
    end_test("keyboard queue");
  endtask

  task automatic test_dma_copy();
    start_test();
    for (int i = 0; i < 8; i++) mem_write(32'h100 + 32'(4 * i), $urandom);
    start_copy(32'h100, 32'h500, 8);
    finish_copy(32'h100, 32'h500, 8);
    end_test("dma copy");
  endtask

  task automatic test_host_during_dma();
    soc_bus_pkg::data_t ctrl;
    start_test();
    for (int i = 0; i < 6; i++) mem_write(32'h600 + 32'(4 * i), $urandom);
    start_copy(32'h600, 32'h700, 6);
    bus_read(dma_reg(soc_dev_pkg::DMA_CTRL_OFS), ctrl);
    check_bit("host_data_o[0] dma busy", ctrl[0], 1'b1);
    // Idle cycle before each access lets the copy win the bus
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      mem_write(32'h800 + 32'(4 * i), $urandom);
      @(negedge clk);
      mem_read_check(32'h800 + 32'(4 * i));
    end
    finish_copy(32'h600, 32'h700, 6);
    end_test("host access during dma");
  endtask

  task automatic test_unmapped();
    soc_bus_pkg::data_t got;
    start_test();
    bus_read(32'hF000_0010, got);
    check_data("host_data_o unmapped", got, soc_bus_pkg::UNMAPPED_DATA);
    end_test("unmapped address");
  endtask

  //////////////////////////////
  // Run
  //////////////////////////////

  initial begin
    void'($urandom(32'h3cd932dc));
    tests        = 0;
    checks       = 0;
    errors       = 0;
    clk          = 1'b0;
    arst_n_i     = 1'b0;
    host_cyc_i   = 1'b0;
    host_we_i    = 1'b0;
    host_strb_i  = '0;
    host_addr_i  = '0;
    host_data_i  = '0;
    key_strobe_i = 1'b0;
    key_code_i   = '0;
    irq_clear_i  = 1'b0;
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
    test_mem_rw();
    test_byte_strobes();
    test_keyboard();
    test_dma_copy();
    test_host_during_dma();
    test_unmapped();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
soc_bus_pkg.sv
soc_dev_pkg.sv
wb_if.sv
wish_bus.sv
main_mem.sv
keyboard.sv
disk_dma.sv
system.sv
system_checker.sv
tb_system.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SoC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_system -f flist.f -o tb_system
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_system)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
exit 1
